// ==== build.f ====
+incdir+verilog
+incdir+verif
verilog/fetchTypes_pkg.sv
verilog/bundleLatch.sv
verilog/preDecode.sv
verilog/btbValidate.sv
verilog/ctiQueue.sv
verilog/fetchStage2.sv
verif/fetchStage2_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module fetchStage2_tb -o fetchStage2_sim

./obj_dir/fetchStage2_sim | tee sim.log

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
exit 0

// ==== verif/fetchModel.svh ====
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

// latch contents as the stage holds them.
logic                       mValid;
pcT                         mPc;
instrT   [`FETCH_WIDTH-1:0] mInstr;
btbLaneS [`FETCH_WIDTH-1:0] mBtb;

// queue pointers.
ctiTagT                     mHead;
ctiTagT                     mTail;
int                         mCount;

// expected outputs for the current cycle.
laneOutS [`FETCH_WIDTH-1:0] expLane;
redirectS                   expRedirect;
logic    [`FETCH_WIDTH-1:0] expMask;
logic                       expFull;

function automatic logic isCtrlOp(instrT instr);
  return instr[31:26] inside {6'h02, 6'h03, 6'h04, 6'h05};
endfunction

function automatic pcT decodedTarget(instrT instr, pcT pc, pcT ras);
  pcT imm;
  imm = pcT'($signed(instr[15:0]));
  if (instr[31:26] == 6'h05) begin
    return ras;
  end
  return pc + 32'd4 + (imm << 2);
endfunction

task automatic resetModel();
  mValid = 1'b0;
  mHead  = '0;
  mTail  = '0;
  mCount = 0;
endtask

task automatic evalExpected(input pcT ras, input logic stall);
  logic seenTaken;
  logic taken;
  logic isRet;
  int   ctrlBefore;
  pcT   lanePc;
  pcT   decoded;
  seenTaken   = 1'b0;
  ctrlBefore  = 0;
  expRedirect = '0;
  expFull     = (mCount > 8);
  for (int i = 0; i < `FETCH_WIDTH; i++) begin
    lanePc  = mPc + pcT'(4 * i);
    decoded = decodedTarget(mInstr[i], lanePc, ras);
    isRet   = (mInstr[i][31:26] == 6'h05);
    taken   = isCtrlOp(mInstr[i]) && (mInstr[i][31:26] != 6'h04 || mBtb[i].prediction);
    expLane[i].valid      = mValid && !seenTaken;
    expMask[i]            = expLane[i].valid && isCtrlOp(mInstr[i]);
    expLane[i].instr      = mInstr[i];
    expLane[i].pc         = lanePc;
    expLane[i].target     = (isRet || !mBtb[i].hit) ? decoded : mBtb[i].target;
    expLane[i].tag        = mTail + ctiTagT'(ctrlBefore);
    expLane[i].prediction = mBtb[i].prediction;
    if (expLane[i].valid && taken && !mBtb[i].hit) begin
      expRedirect.recover  = !stall && !expFull;  // held or full blocks recovery.
      expRedirect.isReturn = isRet;
      expRedirect.isCall   = (mInstr[i][31:26] == 6'h03);
      expRedirect.target   = decoded;
      expRedirect.callPc   = lanePc;
    end
    if (expMask[i]) begin
      ctrlBefore++;
    end
    if (taken) begin
      seenTaken = 1'b1;
    end
  end
endtask

// one rising edge. evalExpected must run first.
task automatic stepModel(input fetchBundleS bundle, input btbLaneS [`FETCH_WIDTH-1:0] btb,
                         input logic stall, input logic flush, input commitCntT commit);
  logic accept;
  int   alloc;
  accept = bundle.valid && !expFull && !stall;
  alloc  = (mValid && !stall) ? $countones(expMask) : 0;
  if (accept) begin
    mPc    = bundle.pc;
    mInstr = bundle.instr;
    mBtb   = btb;
  end
  if (flush) begin
    mValid = 1'b0;
    mTail  = mHead;
    mCount = 0;
  end else begin
    if (!stall) begin
      mValid = accept;
    end
    mHead  = mHead + ctiTagT'(commit);
    mTail  = mTail + ctiTagT'(alloc);
    mCount = mCount + alloc - int'(commit);
  end
endtask

`endif

// ==== verif/fetchStage2_tb.sv ====
`timescale 1ns/1ps

`include "fetch_defines.svh"

module fetchStage2_tb;

  import fetchTypes_pkg::*;

  localparam int ResetLen   = 3;
  localparam int Test1Len   = 20;
  localparam int Test2Len   = 60;
  localparam int Test3Len   = 40;
  localparam int Test4Len   = 50;
  localparam int Test5Len   = 30;
  localparam int CycleLimit = ResetLen + Test1Len + Test2Len + Test3Len + Test4Len +
                              Test5Len + 100;

  logic                       clk;
  logic                       reset_i;
  fetchBundleS                fetchBundle_i;
  btbLaneS [`FETCH_WIDTH-1:0] btbLanes_i;
  pcT                         rasTop_i;
  logic                       stall_i;
  logic                       flush_i;
  commitCntT                  commitCti_i;
  laneOutS [`FETCH_WIDTH-1:0] laneOut_o;
  redirectS                   redirect_o;
  logic                       stageReady_o;
  logic                       ctiQueueFull_o;

  logic [31:0]                rngState;
  int                         cycleCount = 0;
  int                         testErrors = 0;
  int                         totalErrors = 0;
  int                         testsRun = 0;
  int                         testsFailed = 0;
  logic                       holdCheck;
  logic                       sawFull;
  logic                       sawReopen;
  laneOutS [`FETCH_WIDTH-1:0] heldLanes;

  `include "fetchModel.svh"

  fetchStage2 u_fetchStage2 (
    .clk            (clk),
    .reset_i        (reset_i),
    .fetchBundle_i  (fetchBundle_i),
    .btbLanes_i     (btbLanes_i),
    .rasTop_i       (rasTop_i),
    .stall_i        (stall_i),
    .flush_i        (flush_i),
    .commitCti_i    (commitCti_i),
    .laneOut_o      (laneOut_o),
    .redirect_o     (redirect_o),
    .stageReady_o   (stageReady_o),
    .ctiQueueFull_o (ctiQueueFull_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > CycleLimit) begin
      $display("timeout: run went past %0d cycles", CycleLimit);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // mode 0 has no control ops, mode 2 favours returns and BTB misses.
  task automatic randomBundle(input int mode);
    logic [31:0] r;
    logic [5:0]  op;
    r = nextRandom();
    rasTop_i = {r[31:2], 2'b00};
    r = nextRandom();
    fetchBundle_i.valid = 1'b1;
    fetchBundle_i.pc    = {r[31:2], 2'b00};
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      r = nextRandom();
      if (mode == 0 || r[0]) begin
        op = {1'b1, r[5:1]};  // 0x20 to 0x3f.
      end else if (mode == 2 && r[1]) begin
        op = 6'h05;
      end else begin
        op = 6'h02 + 6'(r[3:2]);
      end
      fetchBundle_i.instr[i] = {op, r[31:6]};
      r = nextRandom();
      btbLanes_i[i].hit        = (mode == 2) ? (r[1:0] == 2'b00) : r[0];
      btbLanes_i[i].prediction = r[2];
      btbLanes_i[i].target     = {r[31:3], 3'b000};
    end
  endtask

  // never retire more than the queue holds.
  function automatic commitCntT pickCommit();
    int limit;
    int value;
    limit = (mCount < 4) ? mCount : 4;
    value = int'(nextRandom() % 5);
    if (value > limit) begin
      value = limit;
    end
    return commitCntT'(value);
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      testErrors++;
    end
  endtask

  task automatic compareOutputs();
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      checkValue($sformatf("laneOut_o[%0d].valid", i), 32'(laneOut_o[i].valid),
                 32'(expLane[i].valid));
      checkValue($sformatf("laneOut_o[%0d].tag", i), 32'(laneOut_o[i].tag),
                 32'(expLane[i].tag));
      if (mValid) begin
        checkValue($sformatf("laneOut_o[%0d].instr", i), laneOut_o[i].instr, expLane[i].instr);
        checkValue($sformatf("laneOut_o[%0d].pc", i), laneOut_o[i].pc, expLane[i].pc);
        checkValue($sformatf("laneOut_o[%0d].target", i), laneOut_o[i].target,
                   expLane[i].target);
        checkValue($sformatf("laneOut_o[%0d].prediction", i), 32'(laneOut_o[i].prediction),
                   32'(expLane[i].prediction));
      end
    end
    checkValue("redirect_o.recover", 32'(redirect_o.recover), 32'(expRedirect.recover));
    checkValue("redirect_o.isReturn", 32'(redirect_o.isReturn), 32'(expRedirect.isReturn));
    checkValue("redirect_o.isCall", 32'(redirect_o.isCall), 32'(expRedirect.isCall));
    checkValue("redirect_o.target", redirect_o.target, expRedirect.target);
    checkValue("redirect_o.callPc", redirect_o.callPc, expRedirect.callPc);
    checkValue("stageReady_o", 32'(stageReady_o), 32'(!expFull));
    checkValue("ctiQueueFull_o", 32'(ctiQueueFull_o), 32'(expFull));
  endtask

  // inputs are set at edge + 2 ns, outputs sampled 2 ns before the next edge.
  task automatic runCycle();
    #16;
    evalExpected(rasTop_i, stall_i);
    compareOutputs();
    if (holdCheck) begin
      assert (laneOut_o === heldLanes) else begin
        $display("mismatch laneOut_o under stall: got 0x%h expected 0x%h", laneOut_o, heldLanes);
        testErrors++;
      end
    end
    heldLanes = laneOut_o;
    stepModel(fetchBundle_i, btbLanes_i, stall_i, flush_i, commitCti_i);
    @(posedge clk);
    #2;
  endtask

  task automatic finishTest(input string name);
    testsRun++;
    if (testErrors == 0) begin
      $display("test %0d %s: passed", testsRun, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", testsRun, name, testErrors);
      testsFailed++;
    end
    totalErrors += testErrors;
    testErrors = 0;
  endtask

  initial begin
    logic [31:0] r;
    rngState      = 32'h5023_fab7;
    reset_i       = 1'b1;
    fetchBundle_i = '0;
    btbLanes_i    = '0;
    rasTop_i      = '0;
    stall_i       = 1'b0;
    flush_i       = 1'b0;
    commitCti_i   = '0;
    holdCheck     = 1'b0;
    sawFull       = 1'b0;
    sawReopen     = 1'b0;
    resetModel();
    repeat (ResetLen) @(posedge clk);
    #2;
    reset_i = 1'b0;

    for (int n = 0; n < Test1Len; n++) begin
      randomBundle(0);
      runCycle();
    end
    finishTest("straight-line bundles");

    for (int n = 0; n < Test2Len; n++) begin
      randomBundle(1);
      commitCti_i = pickCommit();
      runCycle();
    end
    finishTest("taken filtering");

    for (int n = 0; n < Test3Len; n++) begin
      randomBundle(2);
      r = nextRandom();
      stall_i     = (r[1:0] == 2'b00);
      commitCti_i = pickCommit();
      runCycle();
    end
    stall_i = 1'b0;
    finishTest("redirect");

    for (int n = 0; n < Test4Len; n++) begin
      randomBundle(1);
      commitCti_i = (n < 30) ? commitCntT'(0) : pickCommit();  // fill first, then drain.
      runCycle();
      if (ctiQueueFull_o) begin
        sawFull = 1'b1;
      end
      if (n >= 30 && sawFull && stageReady_o) begin
        sawReopen = 1'b1;
      end
    end
    assert (sawFull) else begin
      $display("queue never reported full without commits");
      testErrors++;
    end
    assert (sawReopen) else begin
      $display("acceptance did not reopen after commits");
      testErrors++;
    end
    finishTest("tags and fullness");

    for (int n = 0; n < Test5Len / 5; n++) begin
      randomBundle(1);
      commitCti_i = pickCommit();
      runCycle();
      stall_i = 1'b1;
      commitCti_i = pickCommit();
      runCycle();
      r = nextRandom();
      fetchBundle_i.pc = {r[31:2], 2'b00};  // must not be captured.
      holdCheck = 1'b1;
      commitCti_i = pickCommit();
      runCycle();
      commitCti_i = pickCommit();
      runCycle();
      holdCheck   = 1'b0;
      stall_i     = 1'b0;
      flush_i     = 1'b1;
      commitCti_i = pickCommit();
      runCycle();
      flush_i = 1'b0;
      checkValue("laneOut_o[0].tag after flush", 32'(laneOut_o[0].tag), 32'(mHead));
    end
    finishTest("stall and flush");

    $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, totalErrors);
    if (totalErrors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== verilog/btbValidate.sv ====
`timescale 1ns/1ps

`include "fetch_defines.svh"

module btbValidate (
  input  logic                                       bundleValid_i,
  input  fetchTypes_pkg::laneInS [`FETCH_WIDTH-1:0]  lanes_i,
  input  fetchTypes_pkg::preDecS [`FETCH_WIDTH-1:0]  preDec_i,
  output logic                   [`FETCH_WIDTH-1:0]  laneValid_o,
  output fetchTypes_pkg::pcT     [`FETCH_WIDTH-1:0]  finalTarget_o,
  output logic                   [`FETCH_WIDTH-1:0]  ctrlMask_o,
  output fetchTypes_pkg::redirectS                   redirect_o
);

  import fetchTypes_pkg::*;

  logic [`FETCH_WIDTH-1:0] laneTaken;
  logic [`FETCH_WIDTH-1:0] useDecoded;

  // a lane redirects fetch unless it is a branch predicted not taken.
  always_comb begin
    for (int lane = 0; lane < `FETCH_WIDTH; lane++) begin
      laneTaken[lane] = preDec_i[lane].isCtrl &
                        ((preDec_i[lane].ctrlType != ctrlCondBranch) |
                         lanes_i[lane].btb.prediction);
    end
  end

  always_comb begin
    for (int lane = 0; lane < `FETCH_WIDTH; lane++) begin
      useDecoded[lane] = (preDec_i[lane].isCtrl &
                          (preDec_i[lane].ctrlType == ctrlReturn)) |
                         ~lanes_i[lane].btb.hit;
      finalTarget_o[lane] = useDecoded[lane] ? preDec_i[lane].target :
                                               lanes_i[lane].btb.target;
    end
  end

  // lanes after the first taken one are dropped.
  always_comb begin
    logic seenTaken;
    seenTaken  = 1'b0;
    redirect_o = '0;
    for (int lane = 0; lane < `FETCH_WIDTH; lane++) begin
      laneValid_o[lane] = bundleValid_i & ~seenTaken;
      ctrlMask_o[lane]  = bundleValid_i & ~seenTaken & preDec_i[lane].isCtrl;
      if (bundleValid_i && laneTaken[lane] && !seenTaken &&
          !lanes_i[lane].btb.hit) begin
        redirect_o.recover  = 1'b1;  // taken but unknown to the BTB.
        redirect_o.target   = preDec_i[lane].target;
        redirect_o.callPc   = lanes_i[lane].pc;
        redirect_o.isReturn = (preDec_i[lane].ctrlType == ctrlReturn);
        redirect_o.isCall   = (preDec_i[lane].ctrlType == ctrlCall);
      end
      seenTaken = seenTaken | laneTaken[lane];
    end
  end

endmodule

// ==== verilog/bundleLatch.sv ====
`timescale 1ns/1ps

`include "fetch_defines.svh"

module bundleLatch (
  input  logic                                        clk,
  input  logic                                        reset_i,
  input  logic                                        stall_i,
  input  logic                                        flush_i,
  input  logic                                        canAccept_i,
  input  fetchTypes_pkg::fetchBundleS                 fetchBundle_i,
  input  fetchTypes_pkg::btbLaneS [`FETCH_WIDTH-1:0]  btbLanes_i,
  output logic                                        bundleValid_o,
  output fetchTypes_pkg::laneInS  [`FETCH_WIDTH-1:0]  lanes_o
);

  import fetchTypes_pkg::*;

  logic                       accept;
  logic                       validQ;
  pcT                         pcQ;
  instrT   [`FETCH_WIDTH-1:0] instrQ;
  btbLaneS [`FETCH_WIDTH-1:0] btbQ;

  assign accept = fetchBundle_i.valid & canAccept_i & ~stall_i;

  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      validQ <= 1'b0;  // flush wins over accept.
    end else if (!stall_i) begin
      validQ <= accept;
    end
  end

  // payload only moves on accept, so a stall holds it.
  always_ff @(posedge clk) begin
    if (accept) begin
      pcQ    <= fetchBundle_i.pc;
      instrQ <= fetchBundle_i.instr;
      btbQ   <= btbLanes_i;
    end
  end

  always_comb begin
    for (int lane = 0; lane < `FETCH_WIDTH; lane++) begin
      lanes_o[lane].instr = instrQ[lane];
      lanes_o[lane].pc    = pcQ + pcT'(4 * lane);  // 4-byte instructions.
      lanes_o[lane].btb   = btbQ[lane];
    end
  end

  assign bundleValid_o = validQ;

endmodule

// ==== verilog/ctiQueue.sv ====
`timescale 1ns/1ps

`include "fetch_defines.svh"

module ctiQueue (
  input  logic                                       clk,
  input  logic                                       reset_i,
  input  logic                                       flush_i,
  input  logic                                       advance_i,
  input  logic                   [`FETCH_WIDTH-1:0]  ctrlMask_i,
  input  fetchTypes_pkg::commitCntT                  commitCti_i,
  output fetchTypes_pkg::ctiTagT [`FETCH_WIDTH-1:0]  tags_o,
  output logic                                       full_o
);

  import fetchTypes_pkg::*;

  localparam int CntW = $clog2(`FETCH_WIDTH) + 1;

  ctiTagT                  headQ;
  ctiTagT                  tailQ;
  logic [`SIZE_CTI_LOG:0]  countQ;  // 0 to CTI_DEPTH.
  logic [CntW-1:0]         ctrlCnt;
  logic [`SIZE_CTI_LOG:0]  allocCnt;

  // each control lane takes the next free slot in lane order.
  always_comb begin
    logic [CntW-1:0] offset;
    offset = '0;
    for (int lane = 0; lane < `FETCH_WIDTH; lane++) begin
      tags_o[lane] = tailQ + ctiTagT'(offset);  // wraps mod depth.
      offset       = offset + CntW'(ctrlMask_i[lane]);
    end
    ctrlCnt = offset;
  end

  assign allocCnt = advance_i ? (`SIZE_CTI_LOG+1)'(ctrlCnt) : '0;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      headQ  <= '0;
      tailQ  <= '0;
      countQ <= '0;
    end else if (flush_i) begin
      tailQ  <= headQ;
      countQ <= '0;
    end else begin
      headQ  <= headQ + ctiTagT'(commitCti_i);
      tailQ  <= tailQ + ctiTagT'(allocCnt);
      countQ <= countQ + allocCnt - (`SIZE_CTI_LOG+1)'(commitCti_i);
    end
  end

  // room is kept for the held bundle plus one in flight.
  assign full_o = (countQ > (`SIZE_CTI_LOG+1)'(`CTI_DEPTH / 2));

endmodule

// ==== verilog/fetchStage2.sv ====
`timescale 1ns/1ps

`include "fetch_defines.svh"

module fetchStage2 (
  input  logic                                        clk,
  input  logic                                        reset_i,
  input  fetchTypes_pkg::fetchBundleS                 fetchBundle_i,
  input  fetchTypes_pkg::btbLaneS [`FETCH_WIDTH-1:0]  btbLanes_i,
  input  fetchTypes_pkg::pcT                          rasTop_i,
  input  logic                                        stall_i,
  input  logic                                        flush_i,
  input  fetchTypes_pkg::commitCntT                   commitCti_i,
  output fetchTypes_pkg::laneOutS [`FETCH_WIDTH-1:0]  laneOut_o,
  output fetchTypes_pkg::redirectS                    redirect_o,
  output logic                                        stageReady_o,
  output logic                                        ctiQueueFull_o
);

  import fetchTypes_pkg::*;

  logic                      bundleValid;
  laneInS  [`FETCH_WIDTH-1:0] lanes;
  preDecS  [`FETCH_WIDTH-1:0] preDec;
  logic    [`FETCH_WIDTH-1:0] laneValid;
  pcT      [`FETCH_WIDTH-1:0] finalTarget;
  logic    [`FETCH_WIDTH-1:0] ctrlMask;
  redirectS                  rawRedirect;
  ctiTagT  [`FETCH_WIDTH-1:0] tags;
  logic                      ctiFull;
  logic                      advance;

  assign stageReady_o = ~ctiFull;
  assign advance      = bundleValid & ~stall_i;  // bundle leaves this edge.

  bundleLatch u_bundleLatch (
    .clk           (clk),
    .reset_i       (reset_i),
    .stall_i       (stall_i),
    .flush_i       (flush_i),
    .canAccept_i   (stageReady_o),
    .fetchBundle_i (fetchBundle_i),
    .btbLanes_i    (btbLanes_i),
    .bundleValid_o (bundleValid),
    .lanes_o       (lanes)
  );

  for (genvar i = 0; i < `FETCH_WIDTH; i++) begin : genLane
    preDecode u_preDecode (
      .lane_i   (lanes[i]),
      .rasTop_i (rasTop_i),
      .preDec_o (preDec[i])
    );
  end

  btbValidate u_btbValidate (
    .bundleValid_i (bundleValid),
    .lanes_i       (lanes),
    .preDec_i      (preDec),
    .laneValid_o   (laneValid),
    .finalTarget_o (finalTarget),
    .ctrlMask_o    (ctrlMask),
    .redirect_o    (rawRedirect)
  );

  ctiQueue u_ctiQueue (
    .clk         (clk),
    .reset_i     (reset_i),
    .flush_i     (flush_i),
    .advance_i   (advance),
    .ctrlMask_i  (ctrlMask),
    .commitCti_i (commitCti_i),
    .tags_o      (tags),
    .full_o      (ctiFull)
  );

  always_comb begin
    for (int lane = 0; lane < `FETCH_WIDTH; lane++) begin
      laneOut_o[lane].valid      = laneValid[lane];
      laneOut_o[lane].instr      = lanes[lane].instr;
      laneOut_o[lane].pc         = lanes[lane].pc;
      laneOut_o[lane].target     = finalTarget[lane];
      laneOut_o[lane].tag        = tags[lane];
      laneOut_o[lane].prediction = lanes[lane].btb.prediction;
    end
  end

  // no recovery while held or out of queue slots.
  assign redirect_o = '{
    recover:  rawRedirect.recover & ~stall_i & ~ctiFull,
    isReturn: rawRedirect.isReturn,
    isCall:   rawRedirect.isCall,
    target:   rawRedirect.target,
    callPc:   rawRedirect.callPc
  };

  assign ctiQueueFull_o = ctiFull;

endmodule

// ==== verilog/fetchTypes_pkg.sv ====
`include "fetch_defines.svh"

package fetchTypes_pkg;

  typedef logic [`SIZE_PC-1:0] pcT;
  typedef logic [`SIZE_INSTRUCTION-1:0] instrT;
  typedef logic [`SIZE_CTI_LOG-1:0] ctiTagT;
  typedef logic [2:0] commitCntT;  // 0 to 4 retired per cycle.

  typedef enum logic [1:0] {
    ctrlReturn     = 2'b00,
    ctrlCall       = 2'b01,
    ctrlJump       = 2'b10,
    ctrlCondBranch = 2'b11
  } ctrlTypeE;

  // lane i sits at pc + 4*i.
  typedef struct packed {
    logic                         valid;
    pcT                           pc;
    instrT [`FETCH_WIDTH-1:0]     instr;
  } fetchBundleS;

  typedef struct packed {
    logic hit;
    logic prediction;
    pcT   target;
  } btbLaneS;

  typedef struct packed {
    instrT   instr;
    pcT      pc;
    btbLaneS btb;
  } laneInS;

  typedef struct packed {
    logic     isCtrl;
    ctrlTypeE ctrlType;
    pcT       target;
  } preDecS;

  typedef struct packed {
    logic   valid;
    instrT  instr;
    pcT     pc;
    pcT     target;
    ctiTagT tag;
    logic   prediction;
  } laneOutS;

  typedef struct packed {
    logic recover;
    logic isReturn;
    logic isCall;
    pcT   target;
    pcT   callPc;
  } redirectS;

endpackage

// ==== verilog/fetch_defines.svh ====
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// lanes per fetch bundle.
`define FETCH_WIDTH 4

// program counter and instruction widths.
`define SIZE_PC 32
`define SIZE_INSTRUCTION 32

// control transfer queue.
`define CTI_DEPTH 16
`define SIZE_CTI_LOG 4

`endif

// ==== verilog/preDecode.sv ====
`timescale 1ns/1ps

`include "fetch_defines.svh"

module preDecode (
  input  fetchTypes_pkg::laneInS lane_i,
  input  fetchTypes_pkg::pcT     rasTop_i,
  output fetchTypes_pkg::preDecS preDec_o
);

  import fetchTypes_pkg::*;

  localparam logic [5:0] opJump   = 6'h02;
  localparam logic [5:0] opCall   = 6'h03;
  localparam logic [5:0] opBranch = 6'h04;
  localparam logic [5:0] opReturn = 6'h05;

  logic [5:0] opcode;
  pcT         offset;
  pcT         directTarget;

  assign opcode = lane_i.instr[`SIZE_INSTRUCTION-1 -: 6];

  // word offset, sign extended.
  assign offset = {{(`SIZE_PC-18){lane_i.instr[15]}}, lane_i.instr[15:0], 2'b00};

  assign directTarget = lane_i.pc + pcT'(4) + offset;

  always_comb begin
    preDec_o.isCtrl   = 1'b1;
    preDec_o.ctrlType = ctrlJump;
    preDec_o.target   = directTarget;
    case (opcode)
      opJump: begin
        preDec_o.ctrlType = ctrlJump;
      end
      opCall: begin
        preDec_o.ctrlType = ctrlCall;
      end
      opBranch: begin
        preDec_o.ctrlType = ctrlCondBranch;
      end
      opReturn: begin
        preDec_o.ctrlType = ctrlReturn;
        preDec_o.target   = rasTop_i;  // return address from the RAS.
      end
      default: begin
        preDec_o.isCtrl = 1'b0;
      end
    endcase
  end

endmodule
